/* hdl/chip_bus_pkg.sv */
// Peripheral bus widths and the device address map
// Request and response structs for the valid/ready bus
package chip_bus_pkg;

  // Byte address and data widths
  localparam int unsigned BUS_AW = 12;
  localparam int unsigned BUS_DW = 32;

  // Address bits [11:8] pick the device
  localparam int unsigned DEV_SEL_LSB = 8;
  localparam int unsigned DEV_SEL_W   = BUS_AW - DEV_SEL_LSB;

  // Device select codes, all others are unmapped
  localparam int unsigned DEV_GPIO  = 0;
  localparam int unsigned DEV_TIMER = 1;
  localparam int unsigned DEV_PLIC  = 2;

  localparam int unsigned NUM_DEV   = 3;
  localparam int unsigned DEV_IDX_W = $clog2(NUM_DEV);

  typedef struct packed {
    logic [BUS_AW-1:0] addr;
    logic              write;
    logic [BUS_DW-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [BUS_DW-1:0] rdata;
    logic              error;
  } bus_rsp_t;

endpackage

/* hdl/chip_periph_pkg.sv */
// Register offsets of the GPIO, timer and PLIC
// Interrupt numbering, interrupt and pad structs
package chip_periph_pkg;

  localparam int unsigned GPIO_W = 32;

  // GPIO registers
  localparam logic [7:0] GPIO_OUT        = 8'h00;
  localparam logic [7:0] GPIO_OE         = 8'h04;
  localparam logic [7:0] GPIO_IN         = 8'h08;
  localparam logic [7:0] GPIO_INTR_STATE = 8'h0C;
  localparam logic [7:0] GPIO_INTR_EN    = 8'h10;

  // Machine timer registers
  localparam logic [7:0] TMR_CTRL     = 8'h00;
  localparam logic [7:0] TMR_MTIME    = 8'h04;
  localparam logic [7:0] TMR_MTIMECMP = 8'h08;

  // PLIC registers, one priority word per source
  localparam logic [7:0] PLIC_PRIO0     = 8'h00;
  localparam logic [7:0] PLIC_PRIO1     = 8'h04;
  localparam logic [7:0] PLIC_ENABLE    = 8'h10;
  localparam logic [7:0] PLIC_THRESHOLD = 8'h14;
  localparam logic [7:0] PLIC_CLAIM     = 8'h18;
  localparam logic [7:0] PLIC_MSIP      = 8'h1C;

  localparam int unsigned NUM_SRC  = 2;
  localparam int unsigned SRC_ID_W = 2;
  localparam int unsigned PRIO_W   = 2;

  // Bit 0 is source ID 1, ID 0 means no source
  typedef struct packed {
    logic timer;
    logic gpio;
  } periph_intr_t;

  typedef struct packed {
    logic software;
    logic timer;
    logic external;
  } core_irq_t;

  typedef struct packed {
    logic [GPIO_W-1:0] out;
    logic [GPIO_W-1:0] oe;
  } gpio_pad_t;

endpackage

/* hdl/periph_xbar.sv */
// Peripheral crossbar with one host and NUM_DEV devices
// Address decode, response return and error responder
`timescale 1ns/1ps

module periph_xbar
  import chip_bus_pkg::*;
(
  input  logic                     clk_sys_i,
  input  logic                     rst_n_i,

  // Host side
  input  bus_req_t                 host_req_i,
  input  logic                     host_req_valid_i,
  output logic                     host_req_ready_o,
  output bus_rsp_t                 host_rsp_o,
  output logic                     host_rsp_valid_o,
  input  logic                     host_rsp_ready_i,

  // Device side
  output bus_req_t [NUM_DEV-1:0]   dev_req_o,
  output logic     [NUM_DEV-1:0]   dev_req_valid_o,
  input  logic     [NUM_DEV-1:0]   dev_req_ready_i,
  input  bus_rsp_t [NUM_DEV-1:0]   dev_rsp_i,
  input  logic     [NUM_DEV-1:0]   dev_rsp_valid_i,
  output logic     [NUM_DEV-1:0]   dev_rsp_ready_o
);

  logic [DEV_SEL_W-1:0] dev_sel;
  logic [DEV_IDX_W-1:0] dev_idx;
  logic                 mapped;

  // One transaction in flight
  logic                 busy_q;
  logic                 err_q;
  logic [DEV_IDX_W-1:0] sel_q;

  assign dev_sel = host_req_i.addr[BUS_AW-1:DEV_SEL_LSB];
  assign dev_idx = dev_sel[DEV_IDX_W-1:0];
  assign mapped  = dev_sel inside {DEV_GPIO, DEV_TIMER, DEV_PLIC};

  // Unmapped requests are always taken, the error register answers
  assign host_req_ready_o = !busy_q && (!mapped || dev_req_ready_i[dev_idx]);

  always_comb begin
    for (int i = 0; i < NUM_DEV; i++) begin
      dev_req_o[i]       = host_req_i;
      dev_req_valid_o[i] = host_req_valid_i && !busy_q && mapped &&
                           (dev_idx == DEV_IDX_W'(i));
      dev_rsp_ready_o[i] = busy_q && !err_q && (sel_q == DEV_IDX_W'(i)) &&
                           host_rsp_ready_i;
    end
  end

  assign host_rsp_valid_o = busy_q && (err_q || dev_rsp_valid_i[sel_q]);
  assign host_rsp_o       = err_q ? '{rdata: '0, error: 1'b1} : dev_rsp_i[sel_q];

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      err_q  <= 1'b0;
      sel_q  <= '0;
    end else if (host_req_valid_i && host_req_ready_o) begin
      busy_q <= 1'b1;
      err_q  <= !mapped;
      sel_q  <= dev_idx;
    end else if (host_rsp_valid_o && host_rsp_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  // At most one device request valid
  assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    $onehot0(dev_req_valid_o));

  // Stalled response holds its value
  assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    host_rsp_valid_o && !host_rsp_ready_i |=> host_rsp_valid_o && $stable(host_rsp_o));

endmodule

/* hdl/gpio.sv */
// GPIO block with output and output-enable registers
// Two-flop input synchronizer and rising-edge interrupts
`timescale 1ns/1ps

module gpio
  import chip_bus_pkg::*;
  import chip_periph_pkg::*;
(
  input  logic              clk_sys_i,
  input  logic              rst_n_i,

  input  bus_req_t          req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output bus_rsp_t          rsp_o,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,

  input  logic [GPIO_W-1:0] cio_gpio_i,
  output gpio_pad_t         pads_o,
  output logic              intr_o
);

  logic [DEV_SEL_LSB-1:0] off;
  logic                   accept;
  logic                   wr;
  logic [BUS_DW-1:0]      rdata;

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] in_s1_q;
  logic [GPIO_W-1:0] in_s2_q;
  logic [GPIO_W-1:0] in_prev_q;
  logic [GPIO_W-1:0] intr_state_q;
  logic [GPIO_W-1:0] intr_en_q;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] state_clr;

  bus_rsp_t rsp_q;
  logic     rsp_valid_q;

  assign req_ready_o = !rsp_valid_q;
  assign accept      = req_valid_i && req_ready_o;
  assign wr          = accept && req_i.write;
  assign off         = req_i.addr[DEV_SEL_LSB-1:0];

  // Edge seen one cycle after the synchronized value changes
  assign rise      = in_s2_q & ~in_prev_q;
  assign state_clr = (wr && off == GPIO_INTR_STATE) ? req_i.wdata : '0;

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      in_s1_q      <= '0;
      in_s2_q      <= '0;
      in_prev_q    <= '0;
      out_q        <= '0;
      oe_q         <= '0;
      intr_en_q    <= '0;
      intr_state_q <= '0;
    end else begin
      in_s1_q      <= cio_gpio_i;
      in_s2_q      <= in_s1_q;
      in_prev_q    <= in_s2_q;
      // Write 1 to clear, a new edge wins
      intr_state_q <= (intr_state_q & ~state_clr) | rise;
      if (wr) begin
        case (off)
          GPIO_OUT:     out_q     <= req_i.wdata;
          GPIO_OE:      oe_q      <= req_i.wdata;
          GPIO_INTR_EN: intr_en_q <= req_i.wdata;
          default:      ;
        endcase
      end
    end
  end

  always_comb begin
    case (off)
      GPIO_OUT:        rdata = out_q;
      GPIO_OE:         rdata = oe_q;
      GPIO_IN:         rdata = in_s2_q;
      GPIO_INTR_STATE: rdata = intr_state_q;
      GPIO_INTR_EN:    rdata = intr_en_q;
      default:         rdata = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (accept) begin
      rsp_q.rdata <= req_i.write ? '0 : rdata;
      rsp_q.error <= 1'b0;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;
  assign pads_o      = '{out: out_q, oe: oe_q};
  assign intr_o      = |(intr_state_q & intr_en_q);

endmodule

/* hdl/rv_timer.sv */
// Machine timer with free-running mtime and one compare
`timescale 1ns/1ps

module rv_timer
  import chip_bus_pkg::*;
  import chip_periph_pkg::*;
(
  input  logic     clk_sys_i,
  input  logic     rst_n_i,

  input  bus_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output bus_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,

  output logic     intr_o
);

  logic [DEV_SEL_LSB-1:0] off;
  logic                   accept;
  logic                   wr;
  logic [BUS_DW-1:0]      rdata;

  logic              en_q;
  logic [BUS_DW-1:0] mtime_q;
  logic [BUS_DW-1:0] mtimecmp_q;
  logic              intr_q;

  bus_rsp_t rsp_q;
  logic     rsp_valid_q;

  assign req_ready_o = !rsp_valid_q;
  assign accept      = req_valid_i && req_ready_o;
  assign wr          = accept && req_i.write;
  assign off         = req_i.addr[DEV_SEL_LSB-1:0];

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      en_q       <= 1'b0;
      mtime_q    <= '0;
      // Compare starts at the top so the interrupt is low out of reset
      mtimecmp_q <= '1;
      intr_q     <= 1'b0;
    end else begin
      intr_q <= mtime_q >= mtimecmp_q;
      if (wr && off == TMR_CTRL) begin
        en_q <= req_i.wdata[0];
      end
      if (wr && off == TMR_MTIMECMP) begin
        mtimecmp_q <= req_i.wdata;
      end
      // A write to mtime overrides the increment
      if (wr && off == TMR_MTIME) begin
        mtime_q <= req_i.wdata;
      end else if (en_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (off)
      TMR_CTRL:     rdata = {{(BUS_DW-1){1'b0}}, en_q};
      TMR_MTIME:    rdata = mtime_q;
      TMR_MTIMECMP: rdata = mtimecmp_q;
      default:      rdata = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (accept) begin
      rsp_q.rdata <= req_i.write ? '0 : rdata;
      rsp_q.error <= 1'b0;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;
  assign intr_o      = intr_q;

endmodule

/* hdl/rv_plic.sv */
// Simplified PLIC for one target
// Pending and in-service tracking, priority arbitration, claim/complete, MSIP
`timescale 1ns/1ps

module rv_plic
  import chip_bus_pkg::*;
  import chip_periph_pkg::*;
(
  input  logic         clk_sys_i,
  input  logic         rst_n_i,

  input  bus_req_t     req_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,
  output bus_rsp_t     rsp_o,
  output logic         rsp_valid_o,
  input  logic         rsp_ready_i,

  input  periph_intr_t intr_src_i,
  output logic         irq_external_o,
  output logic         irq_software_o
);

  logic [DEV_SEL_LSB-1:0] off;
  logic                   accept;
  logic                   wr;
  logic                   claim_rd;
  logic                   complete;
  logic [BUS_DW-1:0]      rdata;

  logic [NUM_SRC-1:0]             src;
  logic [NUM_SRC-1:0][PRIO_W-1:0] prio_q;
  logic [NUM_SRC-1:0]             enable_q;
  logic [PRIO_W-1:0]              threshold_q;
  logic [NUM_SRC-1:0]             pending_q;
  logic [NUM_SRC-1:0]             in_service_q;
  logic                           msip_q;
  logic                           irq_q;

  logic [SRC_ID_W-1:0] claim_id;
  logic [PRIO_W-1:0]   best_prio;
  logic [NUM_SRC-1:0]  claim_hit;
  logic [NUM_SRC-1:0]  cmpl_hit;

  bus_rsp_t rsp_q;
  logic     rsp_valid_q;

  assign req_ready_o = !rsp_valid_q;
  assign accept      = req_valid_i && req_ready_o;
  assign wr          = accept && req_i.write;
  assign off         = req_i.addr[DEV_SEL_LSB-1:0];
  assign claim_rd    = accept && !req_i.write && off == PLIC_CLAIM;
  assign complete    = wr && off == PLIC_CLAIM;
  assign src         = intr_src_i;

  // Highest priority above threshold, strict compare keeps the lower ID on ties
  always_comb begin
    claim_id  = '0;
    best_prio = threshold_q;
    for (int i = 0; i < NUM_SRC; i++) begin
      if (pending_q[i] && enable_q[i] && prio_q[i] > best_prio) begin
        claim_id  = SRC_ID_W'(i + 1);
        best_prio = prio_q[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_SRC; i++) begin
      claim_hit[i] = claim_rd && claim_id == SRC_ID_W'(i + 1);
      cmpl_hit[i]  = complete && req_i.wdata == BUS_DW'(i + 1);
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      prio_q       <= '0;
      enable_q     <= '0;
      threshold_q  <= '0;
      msip_q       <= 1'b0;
      pending_q    <= '0;
      in_service_q <= '0;
      irq_q        <= 1'b0;
    end else begin
      // Level gateway, no new pending while in service
      pending_q    <= (pending_q | (src & ~in_service_q)) & ~claim_hit;
      in_service_q <= (in_service_q | claim_hit) & ~cmpl_hit;
      irq_q        <= claim_id != '0;
      if (wr) begin
        case (off)
          PLIC_PRIO0:     prio_q[0]   <= req_i.wdata[PRIO_W-1:0];
          PLIC_PRIO1:     prio_q[1]   <= req_i.wdata[PRIO_W-1:0];
          PLIC_ENABLE:    enable_q    <= req_i.wdata[NUM_SRC-1:0];
          PLIC_THRESHOLD: threshold_q <= req_i.wdata[PRIO_W-1:0];
          PLIC_MSIP:      msip_q      <= req_i.wdata[0];
          default:        ;
        endcase
      end
    end
  end

  always_comb begin
    case (off)
      PLIC_PRIO0:     rdata = BUS_DW'(prio_q[0]);
      PLIC_PRIO1:     rdata = BUS_DW'(prio_q[1]);
      PLIC_ENABLE:    rdata = BUS_DW'(enable_q);
      PLIC_THRESHOLD: rdata = BUS_DW'(threshold_q);
      PLIC_CLAIM:     rdata = BUS_DW'(claim_id);
      PLIC_MSIP:      rdata = BUS_DW'(msip_q);
      default:        rdata = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (accept) begin
      rsp_q.rdata <= req_i.write ? '0 : rdata;
      rsp_q.error <= 1'b0;
    end
  end

  assign rsp_o          = rsp_q;
  assign rsp_valid_o    = rsp_valid_q;
  assign irq_external_o = irq_q;
  assign irq_software_o = msip_q;

  // Claim response never names a source that does not exist
  assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    claim_rd |=> rsp_valid_o && rsp_o.rdata <= BUS_DW'(NUM_SRC));

endmodule

/* hdl/top_chip_periph.sv */
// Peripheral subsystem top level
// Crossbar, GPIO, machine timer and PLIC with interrupt packing
`timescale 1ns/1ps

module top_chip_periph
  import chip_bus_pkg::*;
  import chip_periph_pkg::*;
(
  input  logic              clk_sys_i,
  input  logic              rst_n_i,

  // Host port
  input  bus_req_t          host_req_i,
  input  logic              host_req_valid_i,
  output logic              host_req_ready_o,
  output bus_rsp_t          host_rsp_o,
  output logic              host_rsp_valid_o,
  input  logic              host_rsp_ready_i,

  // Pads and core interrupts
  input  logic [GPIO_W-1:0] cio_gpio_i,
  output gpio_pad_t         gpio_pads_o,
  output core_irq_t         core_irq_o
);

  bus_req_t [NUM_DEV-1:0] dev_req;
  logic     [NUM_DEV-1:0] dev_req_valid;
  logic     [NUM_DEV-1:0] dev_req_ready;
  bus_rsp_t [NUM_DEV-1:0] dev_rsp;
  logic     [NUM_DEV-1:0] dev_rsp_valid;
  logic     [NUM_DEV-1:0] dev_rsp_ready;

  logic         gpio_intr;
  logic         timer_intr;
  logic         plic_irq;
  logic         plic_msip;
  periph_intr_t plic_src;

  // Timer goes to the PLIC and straight to the core
  assign plic_src   = '{timer: timer_intr, gpio: gpio_intr};
  assign core_irq_o = '{software: plic_msip, timer: timer_intr, external: plic_irq};

  periph_xbar u_xbar (
    .clk_sys_i,
    .rst_n_i,

    .host_req_i,
    .host_req_valid_i,
    .host_req_ready_o,
    .host_rsp_o,
    .host_rsp_valid_o,
    .host_rsp_ready_i,

    .dev_req_o      (dev_req),
    .dev_req_valid_o(dev_req_valid),
    .dev_req_ready_i(dev_req_ready),
    .dev_rsp_i      (dev_rsp),
    .dev_rsp_valid_i(dev_rsp_valid),
    .dev_rsp_ready_o(dev_rsp_ready)
  );

  gpio u_gpio (
    .clk_sys_i,
    .rst_n_i,
    .req_i      (dev_req[DEV_GPIO]),
    .req_valid_i(dev_req_valid[DEV_GPIO]),
    .req_ready_o(dev_req_ready[DEV_GPIO]),
    .rsp_o      (dev_rsp[DEV_GPIO]),
    .rsp_valid_o(dev_rsp_valid[DEV_GPIO]),
    .rsp_ready_i(dev_rsp_ready[DEV_GPIO]),
    .cio_gpio_i,
    .pads_o     (gpio_pads_o),
    .intr_o     (gpio_intr)
  );

  rv_timer u_rv_timer (
    .clk_sys_i,
    .rst_n_i,
    .req_i      (dev_req[DEV_TIMER]),
    .req_valid_i(dev_req_valid[DEV_TIMER]),
    .req_ready_o(dev_req_ready[DEV_TIMER]),
    .rsp_o      (dev_rsp[DEV_TIMER]),
    .rsp_valid_o(dev_rsp_valid[DEV_TIMER]),
    .rsp_ready_i(dev_rsp_ready[DEV_TIMER]),
    .intr_o     (timer_intr)
  );

  rv_plic u_rv_plic (
    .clk_sys_i,
    .rst_n_i,
    .req_i         (dev_req[DEV_PLIC]),
    .req_valid_i   (dev_req_valid[DEV_PLIC]),
    .req_ready_o   (dev_req_ready[DEV_PLIC]),
    .rsp_o         (dev_rsp[DEV_PLIC]),
    .rsp_valid_o   (dev_rsp_valid[DEV_PLIC]),
    .rsp_ready_i   (dev_rsp_ready[DEV_PLIC]),
    .intr_src_i    (plic_src),
    .irq_external_o(plic_irq),
    .irq_software_o(plic_msip)
  );

endmodule

/* sim/tb_tasks.svh */
// LFSR, compare tasks and bus access tasks for the testbench
// Directed tests for GPIO, crossbar errors, timer and PLIC

// Galois LFSR stepped once per random bit
function automatic logic [31:0] random_bits(input int unsigned nbits);
  logic [31:0] val;
  val = '0;
  for (int unsigned i = 0; i < nbits; i++) begin
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    val    = {val[30:0], lfsr_q[0]};
  end
  return val;
endfunction

task automatic note_failure(input string what);
  errors++;
  $display("Failure: %s", what);
endtask

task automatic expect_true(input logic cond, input string what);
  checks++;
  if (cond !== 1'b1) begin
    note_failure(what);
  end
endtask

task automatic compare_level(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[ERROR] %s: %h, expected %h", name, got, exp);
  end
endtask

task automatic compare_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[ERROR] %s: rdata=%h error=%h, expected rdata=%h error=%h",
             name, got.rdata, got.error, exp.rdata, exp.error);
  end
endtask

task automatic compare_pads(input string name, input gpio_pad_t got, input gpio_pad_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[ERROR] %s: out=%h oe=%h, expected out=%h oe=%h",
             name, got.out, got.oe, exp.out, exp.oe);
  end
endtask

task automatic compare_irq(input string name, input core_irq_t got, input core_irq_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[ERROR] %s: %h, expected %h", name, got, exp);
  end
endtask

task automatic report_test(input string name, input int start);
  tests++;
  $display("%-24s done, %0d errors", name, errors - start);
endtask

// Starts and ends 1 ns after a rising edge
task automatic send_request(input bus_req_t req, output logic ok);
  int unsigned cnt;
  cnt            = 0;
  host_req       = req;
  host_req_valid = 1'b1;
  @(negedge clk_sys);
  while (host_req_ready !== 1'b1 && cnt < WAIT_LIMIT) begin
    @(negedge clk_sys);
    cnt++;
  end
  ok = (host_req_ready === 1'b1);
  if (!ok) begin
    note_failure("request was not accepted within the wait limit");
  end
  @(posedge clk_sys);
  #1;
  host_req_valid = 1'b0;
endtask

// Response is due on the first cycle after the request handshake
task automatic collect_response(output bus_rsp_t rsp, output logic ok);
  int unsigned cnt;
  cnt            = 0;
  host_rsp_ready = 1'b1;
  @(negedge clk_sys);
  while (host_rsp_valid !== 1'b1 && cnt < WAIT_LIMIT) begin
    @(negedge clk_sys);
    cnt++;
  end
  ok  = (host_rsp_valid === 1'b1);
  rsp = host_rsp;
  if (!ok) begin
    note_failure("no response arrived within the wait limit");
  end else if (cnt != 0) begin
    note_failure("response came later than one cycle after the request");
  end
  @(posedge clk_sys);
  #1;
endtask

task automatic bus_read(input int unsigned dev, input logic [7:0] off, output bus_rsp_t rsp);
  bus_req_t req;
  logic     ok;
  req = '{addr: {DEV_SEL_W'(dev), off}, write: 1'b0, wdata: '0};
  rsp = 'x;
  send_request(req, ok);
  if (ok) begin
    collect_response(rsp, ok);
  end
endtask

task automatic bus_write(input int unsigned dev, input logic [7:0] off, input logic [31:0] data);
  bus_req_t req;
  bus_rsp_t rsp;
  logic     ok;
  req = '{addr: {DEV_SEL_W'(dev), off}, write: 1'b1, wdata: data};
  send_request(req, ok);
  if (ok) begin
    collect_response(rsp, ok);
    if (ok) begin
      compare_level("host_rsp_o.error", rsp.error, 1'b0);
    end
  end
endtask

// Polls the masked core interrupt lines until they reach the level
task automatic wait_irq(input logic [2:0] mask, input logic level, input string what);
  int unsigned cnt;
  cnt = 0;
  @(negedge clk_sys);
  while ((|(core_irq & mask)) !== level && cnt < WAIT_LIMIT) begin
    @(negedge clk_sys);
    cnt++;
  end
  expect_true((|(core_irq & mask)) === level,
              $sformatf("%s did not happen within the wait limit", what));
  @(posedge clk_sys);
  #1;
endtask

task automatic check_reset_state();
  int start;
  start = errors;
  @(negedge clk_sys);
  compare_pads("gpio_pads_o", gpio_pads, '0);
  compare_irq("core_irq_o", core_irq, '0);
  compare_level("host_req_ready_o", host_req_ready, 1'b1);
  compare_level("host_rsp_valid_o", host_rsp_valid, 1'b0);
  @(posedge clk_sys);
  #1;
  report_test("reset state", start);
endtask

task automatic gpio_register_test();
  int          start;
  logic [31:0] out_val;
  logic [31:0] oe_val;
  logic [31:0] in_val;
  bus_rsp_t    rsp;
  start   = errors;
  out_val = random_bits(32);
  oe_val  = random_bits(32);
  bus_write(DEV_GPIO, GPIO_OUT, out_val);
  bus_write(DEV_GPIO, GPIO_OE, oe_val);
  @(negedge clk_sys);
  compare_pads("gpio_pads_o", gpio_pads, '{out: out_val, oe: oe_val});
  @(posedge clk_sys);
  #1;
  bus_read(DEV_GPIO, GPIO_OUT, rsp);
  compare_rsp("host_rsp_o", rsp, '{rdata: out_val, error: 1'b0});
  bus_read(DEV_GPIO, GPIO_OE, rsp);
  compare_rsp("host_rsp_o", rsp, '{rdata: oe_val, error: 1'b0});

  // Two synchronizer flops and the edge detector
  in_val   = random_bits(32);
  cio_gpio = in_val;
  repeat (3) @(posedge clk_sys);
  #1;
  bus_read(DEV_GPIO, GPIO_IN, rsp);
  compare_rsp("host_rsp_o", rsp, '{rdata: in_val, error: 1'b0});
  // Every set input bit rose from 0
  bus_read(DEV_GPIO, GPIO_INTR_STATE, rsp);
  compare_rsp("host_rsp_o", rsp, '{rdata: in_val, error: 1'b0});

  cio_gpio = '0;
  bus_write(DEV_GPIO, GPIO_INTR_STATE, '1);
  bus_read(DEV_GPIO, GPIO_INTR_STATE, rsp);
  compare_rsp("host_rsp_o", rsp, '{rdata: '0, error: 1'b0});
  report_test("gpio registers", start);
endtask

task automatic error_and_stall_test();
  int          start;
  logic [31:0] val;
  bus_req_t    req;
  bus_rsp_t    rsp;
  logic        ok;
  start = errors;
  // Select code 5 has no device behind it
  bus_read(5, 8'h00, rsp);
  compare_rsp("host_rsp_o", rsp, '{rdata: '0, error: 1'b1});

  val = random_bits(32);
  bus_write(DEV_GPIO, GPIO_OUT, val);
  req            = '{addr: {DEV_SEL_W'(DEV_GPIO), GPIO_OUT}, write: 1'b0, wdata: '0};
  host_rsp_ready = 1'b0;
  send_request(req, ok);
  for (int i = 0; i < 6 && ok; i++) begin
    @(negedge clk_sys);
    compare_level("host_rsp_valid_o", host_rsp_valid, 1'b1);
    compare_rsp("host_rsp_o", host_rsp, '{rdata: val, error: 1'b0});
    compare_level("host_req_ready_o", host_req_ready, 1'b0);
  end
  @(posedge clk_sys);
  #1;
  if (ok) begin
    collect_response(rsp, ok);
    compare_rsp("host_rsp_o", rsp, '{rdata: val, error: 1'b0});
  end
  host_rsp_ready = 1'b1;
  report_test("errors and stall", start);
endtask

task automatic timer_compare_test();
  int          start;
  logic [31:0] cmp;
  bus_rsp_t    rsp;
  start = errors;
  cmp   = 32'd24 + random_bits(4);
  bus_write(DEV_TIMER, TMR_MTIMECMP, cmp);
  bus_write(DEV_TIMER, TMR_CTRL, 32'd1);
  wait_irq(IRQ_TIMER, 1'b1, "timer interrupt");
  bus_read(DEV_TIMER, TMR_MTIME, rsp);
  compare_level("host_rsp_o.error", rsp.error, 1'b0);
  checks++;
  if ((rsp.rdata >= cmp) !== 1'b1) begin
    errors++;
    $display("[ERROR] host_rsp_o.rdata: mtime=%h, expected at least mtimecmp=%h",
             rsp.rdata, cmp);
  end
  report_test("timer compare", start);
endtask

task automatic plic_claim_test();
  int         start;
  logic [4:0] pin;
  bus_rsp_t   rsp;
  start = errors;
  pin   = 5'(random_bits(5));
  // GPIO as source 1 at priority 1 and timer as source 2 at priority 3
  bus_write(DEV_PLIC, PLIC_PRIO0, 32'd1);
  bus_write(DEV_PLIC, PLIC_PRIO1, 32'd3);
  bus_write(DEV_PLIC, PLIC_THRESHOLD, 32'd0);
  bus_write(DEV_PLIC, PLIC_ENABLE, 32'd1);
  @(negedge clk_sys);
  compare_level("core_irq_o.external", core_irq.external, 1'b0);
  @(posedge clk_sys);
  #1;

  bus_write(DEV_GPIO, GPIO_INTR_EN, 32'd1 << pin);
  cio_gpio[pin] = 1'b1;
  wait_irq(IRQ_EXT, 1'b1, "external interrupt from GPIO");
  bus_write(DEV_PLIC, PLIC_ENABLE, 32'd3);
  bus_read(DEV_PLIC, PLIC_CLAIM, rsp);
  compare_rsp("host_rsp_o", rsp, '{rdata: 32'd2, error: 1'b0});
  bus_read(DEV_PLIC, PLIC_CLAIM, rsp);
  compare_rsp("host_rsp_o", rsp, '{rdata: 32'd1, error: 1'b0});
  wait_irq(IRQ_EXT, 1'b0, "external interrupt release");

  // Completion makes the still high timer level pending again
  bus_write(DEV_PLIC, PLIC_CLAIM, 32'd2);
  wait_irq(IRQ_EXT, 1'b1, "external interrupt after complete");
  bus_read(DEV_PLIC, PLIC_CLAIM, rsp);
  compare_rsp("host_rsp_o", rsp, '{rdata: 32'd2, error: 1'b0});

  bus_write(DEV_PLIC, PLIC_MSIP, 32'd1);
  @(negedge clk_sys);
  compare_irq("core_irq_o", core_irq, '{software: 1'b1, timer: 1'b1, external: 1'b0});
  @(posedge clk_sys);
  #1;
  report_test("plic claim", start);
endtask

/* sim/tb_top_chip_periph.sv */
// Testbench for the peripheral subsystem
// Clock, reset, DUT instance, directed test sequence and closing counts
`timescale 1ns/1ps

module tb_top_chip_periph
  import chip_bus_pkg::*;
  import chip_periph_pkg::*;
();

  localparam int unsigned WAIT_LIMIT = 200;

  // Masks over core_irq_t, MSB first: software, timer, external
  localparam logic [2:0] IRQ_EXT   = 3'b001;
  localparam logic [2:0] IRQ_TIMER = 3'b010;

  logic              clk_sys;
  logic              rst_n;
  bus_req_t          host_req;
  logic              host_req_valid;
  logic              host_req_ready;
  bus_rsp_t          host_rsp;
  logic              host_rsp_valid;
  logic              host_rsp_ready;
  logic [GPIO_W-1:0] cio_gpio;
  gpio_pad_t         gpio_pads;
  core_irq_t         core_irq;

  // Result counters and LFSR state
  int          errors;
  int          checks;
  int          tests;
  logic [31:0] lfsr_q;

  `include "tb_tasks.svh"

  top_chip_periph top_chip_periph_inst (
    .clk_sys_i       (clk_sys),
    .rst_n_i         (rst_n),
    .host_req_i      (host_req),
    .host_req_valid_i(host_req_valid),
    .host_req_ready_o(host_req_ready),
    .host_rsp_o      (host_rsp),
    .host_rsp_valid_o(host_rsp_valid),
    .host_rsp_ready_i(host_rsp_ready),
    .cio_gpio_i      (cio_gpio),
    .gpio_pads_o     (gpio_pads),
    .core_irq_o      (core_irq)
  );

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  initial begin
    rst_n          = 1'b0;
    host_req       = '0;
    host_req_valid = 1'b0;
    host_rsp_ready = 1'b0;
    cio_gpio       = '0;
    errors         = 0;
    checks         = 0;
    tests          = 0;
    lfsr_q         = 32'd19;

    // Synchronous reset over 8 rising edges
    repeat (8) @(posedge clk_sys);
    #1;
    rst_n = 1'b1;

    check_reset_state();
    gpio_register_test();
    error_and_stall_test();
    timer_compare_test();
    plic_claim_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+sim
hdl/chip_bus_pkg.sv
hdl/chip_periph_pkg.sv
hdl/periph_xbar.sv
hdl/gpio.sv
hdl/rv_timer.sv
hdl/rv_plic.sv
hdl/top_chip_periph.sv
sim/tb_top_chip_periph.sv

/* Bender.yml */
package:
  name: chip_periph

sources:
  - hdl/chip_bus_pkg.sv
  - hdl/chip_periph_pkg.sv
  - hdl/periph_xbar.sv
  - hdl/gpio.sv
  - hdl/rv_timer.sv
  - hdl/rv_plic.sv
  - hdl/top_chip_periph.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_top_chip_periph.sv
